// File: fb_defs.svh
// Frame buffer read side shared widths, burst limits and back buffer thresholds
`ifndef FB_DEFS_SVH
`define FB_DEFS_SVH

// --------------------
// Frame pointer and configuration widths
// --------------------
`define FB_PTR_W         3   // Up to eight frames
`define FB_SIZE_W        23  // Frame size in 32-bit words
`define FB_WADDR_W       17  // Writer address width

// --------------------
// Memory port
// --------------------
`define FB_BADDR_W       30  // Byte address into DDR
`define FB_BL_MAX        32  // Largest burst in words

// Byte distance between frame bases, one fixed stride
`define FB_FRAME_STRIDE  (30'd1 << 24)

// --------------------
// Back buffer
// --------------------
`define FB_FIFO_AW       8   // 256 entries
`define FB_FIFO_PF       180 // Stops new bursts here
`define FB_FIFO_PE       6   // Prog empty for the video side

// Headroom between PF and depth must hold all outstanding burst data

// --------------------
// Clock crossing
// --------------------
`define FB_SYNC_STAGES   2   // Flops per synchronizer chain

`endif

// File: fb_cfg_pkg.sv
// Frame configuration and frame pointer types for the read side
`include "fb_defs.svh"

package fb_cfg_pkg;

	// Frame pointer into the DDR frame ring
	typedef logic [`FB_PTR_W-1:0] fb_ptr_t;

	// Video-side frame configuration, 27 bits
	typedef struct packed {
		logic                  en;    // Read enable
		logic [`FB_PTR_W-1:0]  depth; // Frames minus one
		logic [`FB_SIZE_W-1:0] size;  // Words per frame
	} fb_cfg_t;

endpackage

// File: fb_mem_pkg.sv
// Memory controller command, read FIFO status and image word types
`include "fb_defs.svh"

package fb_mem_pkg;

	// Command opcodes of the memory controller port
	localparam logic [2:0] MEM_INSTR_RD = 3'd1;

	// --------------------
	// Command port
	// --------------------
	typedef struct packed {
		logic [2:0]             instr;     // 1 is read
		logic [5:0]             bl;        // Burst length minus one
		logic [`FB_BADDR_W-1:0] byte_addr;
	} mem_cmd_t;

	// --------------------
	// Read data FIFO levels
	// --------------------
	typedef struct packed {
		logic empty;
		logic full;
	} mem_rd_stat_t;

	// --------------------
	// Back buffer payload
	// --------------------
	typedef struct packed {
		logic        last; // Final word of the frame
		logic [31:0] data;
	} img_word_t;

endpackage

// File: fb_rd_cfg.sv
// Brings the video-side frame settings into the memory clock, latched at frame start
`timescale 1ns/1ps
`include "fb_defs.svh"

module fb_rd_cfg import fb_cfg_pkg::*; (
	input  logic    clk,
	input  logic    i_arst_n,
	input  fb_cfg_t i_cfg,         // Video clock domain
	input  logic    i_frame_start, // One pulse per frame
	output fb_cfg_t o_cfg
);

	// --------------------
	// Synchronizer chain
	// --------------------
	fb_cfg_t sync_q [`FB_SYNC_STAGES]; // Stage 0 samples the async bus
	fb_cfg_t cfg_sync;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < `FB_SYNC_STAGES; i++) begin
				sync_q[i] <= '0;
			end
		end else begin
			sync_q[0] <= i_cfg; // Per bit, values are held steady by the video side
			for (int i = 1; i < `FB_SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	assign cfg_sync = sync_q[`FB_SYNC_STAGES-1];

	// --------------------
	// Shadow copy
	// --------------------
	// Depth and size only move at a frame boundary
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_cfg <= '0;
		end else begin
			o_cfg.en <= cfg_sync.en; // Disable acts at once
			if (i_frame_start) begin
				o_cfg.depth <= cfg_sync.depth;
				o_cfg.size  <= cfg_sync.size;
			end
		end
	end

endmodule

// File: fb_async_fifo.sv
// Dual-clock back buffer with Gray pointers and programmable full and empty flags
`timescale 1ns/1ps
`include "fb_defs.svh"

module fb_async_fifo import fb_mem_pkg::*; (
	input  logic      i_arst_n,
	input  logic      i_rst,        // From write domain, clears both sides
	input  logic      wr_clk,
	input  logic      i_wr_en,
	input  img_word_t i_din,
	output logic      o_full,
	output logic      o_prog_full,
	input  logic      rd_clk,
	input  logic      i_rd_en,
	output img_word_t o_dout,       // Show-ahead
	output logic      o_empty,
	output logic      o_prog_empty
);

	localparam int AW = `FB_FIFO_AW;

	img_word_t mem [2**AW]; // 256 entries

	logic          arst_n;
	logic [AW:0]   wr_bin;
	logic [AW:0]   wr_gray;
	logic [AW:0]   rd_bin;
	logic [AW:0]   rd_gray;
	logic [AW:0]   wr_bin_nxt;
	logic [AW:0]   rd_bin_nxt;
	logic [AW:0]   rd_gray_s1;
	logic [AW:0]   rd_gray_s2;
	logic [AW:0]   wr_gray_s1;
	logic [AW:0]   wr_gray_s2;
	logic [AW:0]   rd_bin_s;   // Read pointer seen by write side
	logic [AW:0]   wr_bin_s;   // Write pointer seen by read side
	logic [AW:0]   wr_level;
	logic [AW:0]   rd_level;
	logic          wr_ok;
	logic          rd_ok;

	function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
		logic [AW:0] b;
		b[AW] = g[AW];
		for (int i = AW - 1; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	assign arst_n = i_arst_n & ~i_rst;

	// --------------------
	// Write side
	// --------------------
	assign wr_ok      = i_wr_en && !o_full;
	assign wr_bin_nxt = wr_bin + 1'b1;

	always_ff @(posedge wr_clk) begin
		if (wr_ok) mem[wr_bin[AW-1:0]] <= i_din;
	end

	always_ff @(posedge wr_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_bin     <= '0;
			wr_gray    <= '0;
			rd_gray_s1 <= '0;
			rd_gray_s2 <= '0;
		end else begin
			if (wr_ok) begin
				wr_bin  <= wr_bin_nxt;
				wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
			end
			rd_gray_s1 <= rd_gray;    // Two-stage sync
			rd_gray_s2 <= rd_gray_s1;
		end
	end

	assign rd_bin_s    = gray2bin(rd_gray_s2);
	assign o_full      = wr_gray == {~rd_gray_s2[AW:AW-1], rd_gray_s2[AW-2:0]};
	assign wr_level    = wr_bin - rd_bin_s; // Pessimistic, reads seen late
	assign o_prog_full = wr_level >= (AW+1)'(`FB_FIFO_PF);

	// --------------------
	// Read side
	// --------------------
	assign rd_ok      = i_rd_en && !o_empty;
	assign rd_bin_nxt = rd_bin + 1'b1;

	always_ff @(posedge rd_clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_bin     <= '0;
			rd_gray    <= '0;
			wr_gray_s1 <= '0;
			wr_gray_s2 <= '0;
		end else begin
			if (rd_ok) begin
				rd_bin  <= rd_bin_nxt;
				rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
			end
			wr_gray_s1 <= wr_gray;
			wr_gray_s2 <= wr_gray_s1;
		end
	end

	assign wr_bin_s     = gray2bin(wr_gray_s2);
	assign o_empty      = rd_gray == wr_gray_s2;
	assign rd_level     = wr_bin_s - rd_bin;
	assign o_prog_empty = rd_level <= (AW+1)'(`FB_FIFO_PE);
	assign o_dout       = mem[rd_bin[AW-1:0]]; // Head word, no read latency

endmodule

// File: fb_rd_ctrl.sv
// Read controller: frame pointer pick, writer handshake, burst issue and data move
`timescale 1ns/1ps
`include "fb_defs.svh"

module fb_rd_ctrl import fb_cfg_pkg::*, fb_mem_pkg::*; (
	input  logic         clk,
	input  logic         i_arst_n,
	input  fb_cfg_t      i_cfg,          // Shadowed frame settings
	output logic         o_frame_start,  // Latches a new config
	output fb_ptr_t      o_rd_ptr,
	output logic         o_rd_req,       // Held until ack
	input  logic         i_rd_ack,
	output logic         o_reading,
	input  fb_ptr_t      i_wr_frame_ptr,
	input  logic         i_writing,
	input  logic         i_calib_done,
	output logic         o_cmd_en,       // One-cycle pulse
	output mem_cmd_t     o_cmd,
	input  logic         i_cmd_full,
	output logic         o_mem_rd_en,    // Pops the memory read FIFO
	input  logic [31:0]  i_mem_rd_data,  // Show-ahead data
	input  mem_rd_stat_t i_mem_rd_stat,
	output logic         o_buf_rst,      // Back buffer reset, 4 cycles
	output logic         o_buf_wr,
	output img_word_t    o_buf_din,
	input  logic         i_buf_pf
);

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_issue,
		st_drain   // All bursts out, data still coming
	} state_t;

	state_t                 state;
	logic [`FB_SIZE_W-1:0]  cmd_cnt;  // Words commanded
	logic [`FB_SIZE_W-1:0]  xfer_cnt; // Words moved to back buffer
	logic [`FB_SIZE_W-1:0]  remain;
	logic [`FB_SIZE_W-1:0]  burst;
	logic [5:0]             burst_bl;
	logic [`FB_BADDR_W-1:0] frame_base;
	logic [`FB_BADDR_W-1:0] word_offset;
	fb_ptr_t                ptr_pick;
	logic                   en_d;
	logic                   en_fall;
	logic [1:0]             rst_cnt;
	logic                   cmd_ok;
	logic                   pop_img;
	logic                   flush;
	logic                   last_pop;

	// --------------------
	// Frame pointer choice
	// --------------------
	always_comb begin
		if (i_writing) begin
			// Writer busy, take the frame before it
			if (i_wr_frame_ptr == '0) begin
				ptr_pick = i_cfg.depth; // Wrap to the top frame
			end else begin
				ptr_pick = i_wr_frame_ptr - 1'b1;
			end
		end else begin
			ptr_pick = i_wr_frame_ptr;
		end
	end

	// --------------------
	// Burst sizing and address
	// --------------------
	assign remain      = i_cfg.size - cmd_cnt;
	assign burst       = (remain > `FB_BL_MAX) ? `FB_SIZE_W'(`FB_BL_MAX) : remain;
	assign burst_bl    = burst[5:0] - 6'd1;          // 32 wraps to 31
	assign frame_base  = o_rd_ptr * `FB_FRAME_STRIDE;
	assign word_offset = {{(`FB_BADDR_W-`FB_SIZE_W-2){1'b0}}, cmd_cnt, 2'b00};

	assign cmd_ok = (state == st_issue) && (cmd_cnt < i_cfg.size) && !i_cmd_full
		&& !i_buf_pf && i_calib_done && !o_cmd_en; // Keep pulses apart

	// --------------------
	// Memory read FIFO pop
	// --------------------
	assign pop_img  = ((state == st_issue) || (state == st_drain))
		&& (xfer_cnt != i_cfg.size) && !i_mem_rd_stat.empty;
	assign flush    = (state == st_idle) && !i_cfg.en && !i_mem_rd_stat.empty; // Stale data
	assign last_pop = pop_img && (xfer_cnt == i_cfg.size - 1'b1);

	assign o_mem_rd_en   = pop_img || flush;
	assign o_frame_start = (state == st_idle) && i_cfg.en && !o_buf_rst;

	assign en_fall = en_d && !i_cfg.en;

	// --------------------
	// Control FSM
	// --------------------
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state     <= st_idle;
			o_rd_req  <= 1'b0;
			o_reading <= 1'b0;
			o_rd_ptr  <= '0;
			o_cmd_en  <= 1'b0;
			o_buf_wr  <= 1'b0;
			o_buf_rst <= 1'b0;
			cmd_cnt   <= '0;
			xfer_cnt  <= '0;
			en_d      <= 1'b0;
			rst_cnt   <= '0;
		end else begin
			en_d     <= i_cfg.en;
			o_cmd_en <= 1'b0;
			o_buf_wr <= pop_img;

			// Back buffer reset on enable fall
			if (en_fall) begin
				o_buf_rst <= 1'b1;
				rst_cnt   <= 2'd3;
			end else if (rst_cnt != 2'd0) begin
				rst_cnt <= rst_cnt - 2'd1;
			end else begin
				o_buf_rst <= 1'b0;
			end

			if (pop_img) xfer_cnt <= xfer_cnt + 1'b1;

			if (!i_cfg.en) begin
				state     <= st_idle; // Abort, buffer gets reset
				o_rd_req  <= 1'b0;
				o_reading <= 1'b0;
			end else begin
				case (state)
					st_idle: begin
						if (o_frame_start) begin
							state    <= st_request;
							o_rd_req <= 1'b1;
						end
					end
					st_request: begin
						if (i_rd_ack) begin
							o_rd_req  <= 1'b0;
							o_reading <= 1'b1;
							o_rd_ptr  <= ptr_pick;
							cmd_cnt   <= '0;
							xfer_cnt  <= '0;
							state     <= st_issue;
						end
					end
					st_issue: begin
						if (cmd_ok) begin
							o_cmd_en <= 1'b1;
							cmd_cnt  <= cmd_cnt + burst;
							if (cmd_cnt + burst == i_cfg.size) state <= st_drain;
						end
					end
					default: begin
						// Drain, finishes on the last buffer write
					end
				endcase

				if (o_buf_wr && o_buf_din.last) begin
					o_reading <= 1'b0; // Frame fully in back buffer
					state     <= st_idle;
				end
			end
		end
	end

	// --------------------
	// Payload registers
	// --------------------
	always_ff @(posedge clk) begin
		if (cmd_ok) begin
			o_cmd.instr     <= MEM_INSTR_RD;
			o_cmd.bl        <= burst_bl;
			o_cmd.byte_addr <= frame_base + word_offset;
		end
		o_buf_din.data <= i_mem_rd_data;
		o_buf_din.last <= last_pop; // Final word of frame
	end

endmodule

// File: fb_rd_top.sv
// Frame buffer read side: config sync, read controller and back buffer
`timescale 1ns/1ps
`include "fb_defs.svh"

module fb_rd_top import fb_cfg_pkg::*, fb_mem_pkg::*; (
	// --------------------
	// Video output clock
	// --------------------
	input  logic                  clk_vout,
	input  logic                  i_buf_rd,       // Plain read strobe
	output logic                  o_buf_empty,
	output logic                  o_buf_pe,
	output img_word_t             o_image_dout,
	// Frame settings, not yet synchronized
	input  logic                  i_frame_en,
	input  fb_ptr_t               i_frame_depth,
	input  logic [`FB_SIZE_W-1:0] i_frame_size,
	// --------------------
	// Memory clock
	// --------------------
	input  logic                  clk,
	input  logic                  i_arst_n,
	output fb_ptr_t               o_rd_ptr,
	output logic                  o_rd_req,
	input  logic                  i_rd_ack,
	output logic                  o_reading,
	input  fb_ptr_t               i_wr_frame_ptr,
	input  logic                  i_writing,
	input  logic                  i_calib_done,
	output logic                  o_cmd_en,
	output mem_cmd_t              o_cmd,
	input  logic                  i_cmd_full,
	output logic                  o_mem_rd_en,
	input  logic [31:0]           i_mem_rd_data,
	input  mem_rd_stat_t          i_mem_rd_stat
);

	fb_cfg_t   cfg;          // Settings in memory clock
	logic      frame_start;
	logic      buf_rst;
	logic      buf_wr;
	img_word_t buf_din;
	logic      buf_pf;

	fb_rd_cfg fb_rd_cfg_inst (
		.clk           (clk),
		.i_arst_n      (i_arst_n),
		.i_cfg         ({i_frame_en, i_frame_depth, i_frame_size}),
		.i_frame_start (frame_start),
		.o_cfg         (cfg)
	);

	fb_rd_ctrl fb_rd_ctrl_inst (
		.clk            (clk),
		.i_arst_n       (i_arst_n),
		.i_cfg          (cfg),
		.o_frame_start  (frame_start),
		.o_rd_ptr       (o_rd_ptr),
		.o_rd_req       (o_rd_req),
		.i_rd_ack       (i_rd_ack),
		.o_reading      (o_reading),
		.i_wr_frame_ptr (i_wr_frame_ptr),
		.i_writing      (i_writing),
		.i_calib_done   (i_calib_done),
		.o_cmd_en       (o_cmd_en),
		.o_cmd          (o_cmd),
		.i_cmd_full     (i_cmd_full),
		.o_mem_rd_en    (o_mem_rd_en),
		.i_mem_rd_data  (i_mem_rd_data),
		.i_mem_rd_stat  (i_mem_rd_stat),
		.o_buf_rst      (buf_rst),
		.o_buf_wr       (buf_wr),
		.o_buf_din      (buf_din),
		.i_buf_pf       (buf_pf)
	);

	// Prog full keeps burst data in flight below the real full level
	fb_async_fifo back_buf_inst (
		.i_arst_n     (i_arst_n),
		.i_rst        (buf_rst),
		.wr_clk       (clk),
		.i_wr_en      (buf_wr),
		.i_din        (buf_din),
		.o_full       (),
		.o_prog_full  (buf_pf),
		.rd_clk       (clk_vout),
		.i_rd_en      (i_buf_rd),
		.o_dout       (o_image_dout),
		.o_empty      (o_buf_empty),
		.o_prog_empty (o_buf_pe)
	);

endmodule

// File: tb_fb_rd_top.sv
// Testbench for the frame buffer read side, with writer, memory and video reader models
`timescale 1ns/1ps
`include "fb_defs.svh"

module tb_fb_rd_top
	import fb_cfg_pkg::*, fb_mem_pkg::*;
();

	localparam int SEED    = 32'hdfd939f4;
	localparam int NFRAMES = 8;

	logic                  clk            = 1'b0;
	logic                  clk_vout       = 1'b1;
	logic                  i_arst_n       = 1'b0;
	logic                  i_buf_rd       = 1'b0;
	logic                  o_buf_empty;
	logic                  o_buf_pe;
	img_word_t             o_image_dout;
	logic                  i_frame_en     = 1'b0;
	fb_ptr_t               i_frame_depth  = 3'd3;
	logic [`FB_SIZE_W-1:0] i_frame_size   = 23'd100;
	fb_ptr_t               o_rd_ptr;
	fb_ptr_t               i_wr_frame_ptr = '0;
	logic                  o_rd_req;
	logic                  i_rd_ack       = 1'b0;
	logic                  o_reading;
	logic                  i_writing      = 1'b0;
	logic                  i_calib_done   = 1'b0;
	logic                  o_cmd_en;
	logic                  i_cmd_full     = 1'b0;
	logic                  o_mem_rd_en;
	mem_cmd_t              o_cmd;
	logic [31:0]           i_mem_rd_data  = '0;
	mem_rd_stat_t          i_mem_rd_stat  = 2'b10; // Empty, not full

	integer      seed_main = SEED;
	integer      seed_mem  = SEED + 1;
	integer      seed_rd   = SEED + 2;
	img_word_t   exp_q [$];  // Words the video side should see
	logic [31:0] pend_q [$]; // Commanded addresses not yet returned
	logic [31:0] rdq [$];    // Memory read FIFO content
	logic [31:0] cur_base;
	int          cur_size;
	int          cmd_words;
	int          f_depth;
	int          wr_ptr;
	int          exp_ptr;
	int          exp_bl;
	logic        frame_on = 1'b0;
	logic        rd_slow  = 1'b0;
	logic        rd_hold  = 1'b0; // Video side stalled
	logic        mem_pop;
	logic        mem_cmd;
	logic        wr_busy;
	mem_cmd_t    cmd_s;
	img_word_t   w;
	img_word_t   got_w;

	fb_rd_top fb_rd_top_inst (.*);

	always #20 clk = ~clk;
	always begin
		#13 clk_vout = ~clk_vout; // Rises 13 ns after clk
		#7;
	end

	task automatic stop_run(input string why);
		$display("ERROR t=%0t %s", $time, why);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "run stopped at first error");
		end
	endtask

	// --------------------
	// Memory controller model
	// --------------------
	always begin
		@(negedge clk);
		mem_pop = o_mem_rd_en && !i_mem_rd_stat.empty; // Acted on at next edge
		mem_cmd = o_cmd_en;
		cmd_s   = o_cmd;
		@(posedge clk);
		#2;
		if (mem_pop) void'(rdq.pop_front());
		if (mem_cmd) begin
			for (int i = 0; i <= int'(cmd_s.bl); i++) pend_q.push_back(cmd_s.byte_addr + 4 * i);
		end
		if (pend_q.size() > 0 && ($random(seed_mem) & 3) != 0) begin
			rdq.push_back(pend_q.pop_front() ^ 32'h5a5a0000); // Random return gaps
		end
		i_mem_rd_stat.empty = (rdq.size() == 0);
		i_mem_rd_data       = (rdq.size() == 0) ? '0 : rdq[0];
		// Small command queue keeps outstanding data under the back buffer headroom
		i_cmd_full = (($random(seed_mem) & 7) == 0) || (pend_q.size() + rdq.size() > 24);
	end

	// Burst command checks
	always begin
		@(negedge clk);
		if (o_cmd_en) begin
			if (!frame_on) begin
				stop_run("memory command issued outside a frame");
			end else begin
				exp_bl = (cur_size - cmd_words > `FB_BL_MAX) ? `FB_BL_MAX : cur_size - cmd_words;
				check_val("o_cmd.instr", o_cmd.instr, 1);
				check_val("o_cmd.byte_addr", o_cmd.byte_addr, cur_base + 4 * cmd_words);
				check_val("o_cmd.bl", int'(o_cmd.bl) + 1, exp_bl);
				cmd_words = cmd_words + int'(o_cmd.bl) + 1;
			end
		end
	end

	// --------------------
	// Video reader
	// --------------------
	always begin
		@(negedge clk_vout);
		if (i_buf_rd && !o_buf_empty) begin
			if (exp_q.size() == 0) begin
				stop_run("video side read a word that the model does not expect");
			end else begin
				got_w = o_image_dout;
				check_val("o_image_dout", got_w, exp_q.pop_front());
			end
		end
		@(posedge clk_vout);
		#2;
		i_buf_rd = !rd_hold && !o_buf_empty && (rd_slow ? ($random(seed_rd) & 7) == 0
			: ($random(seed_rd) & 3) != 0); // Slow mode drives prog full
	end

	// --------------------
	// Wait loops
	// --------------------
	task automatic wait_req(input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!o_rd_req) begin
			n++;
			if (n > 2000) stop_run(what);
			@(negedge clk);
		end
	endtask

	task automatic wait_frame_done();
		int n;
		n = 0;
		@(negedge clk);
		while (o_reading) begin
			n++;
			if (n > 60000) stop_run("frame never finished reading");
			@(negedge clk);
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			n++;
			if (n > 60000) stop_run("video side never received the whole frame");
			@(negedge clk);
		end
	endtask

	task automatic wait_buf_filled();
		int n;
		n = 0;
		@(negedge clk_vout);
		while (o_buf_pe) begin
			n++;
			if (n > 2000) stop_run("back buffer never filled with the video side stalled");
			@(negedge clk_vout);
		end
	endtask

	// Writer handshake, pointer check and model fill for one frame
	task automatic answer_request(input int idx);
		repeat (1 + $unsigned($random(seed_main)) % 5) @(posedge clk);
		#2;
		f_depth  = i_frame_depth; // Settings latched for this frame
		cur_size = i_frame_size;
		wr_ptr   = $unsigned($random(seed_main)) % (f_depth + 1);
		wr_busy  = $random(seed_main) & 1;
		exp_ptr  = wr_busy ? ((wr_ptr == 0) ? f_depth : wr_ptr - 1) : wr_ptr;
		cur_base = 32'(exp_ptr) << 24; // Fixed frame stride
		cmd_words = 0;
		frame_on  = 1'b1;
		rd_slow   = (idx % 3 == 1);
		for (int i = 0; i < cur_size; i++) begin
			w.last = (i == cur_size - 1);
			w.data = (cur_base + 4 * i) ^ 32'h5a5a0000;
			exp_q.push_back(w);
		end
		i_wr_frame_ptr = wr_ptr;
		i_writing      = wr_busy;
		i_rd_ack       = 1'b1;
		@(posedge clk);
		#2;
		i_rd_ack      = 1'b0;
		i_frame_size  = 40 + $unsigned($random(seed_main)) % 360; // Mid-frame change
		i_frame_depth = $random(seed_main);
		@(negedge clk);
		check_val("o_reading", o_reading, 1);
		check_val("o_rd_ptr", o_rd_ptr, exp_ptr);
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		repeat (3) @(negedge clk);
		check_val("o_rd_req", o_rd_req, 0); // Inside reset
		check_val("o_cmd_en", o_cmd_en, 0);
		check_val("o_reading", o_reading, 0);
		check_val("o_mem_rd_en", o_mem_rd_en, 0);
		check_val("o_buf_empty", o_buf_empty, 1);
		check_val("o_buf_pe", o_buf_pe, 1);
		repeat (2) @(posedge clk);
		#2;
		i_arst_n     = 1'b1;
		i_calib_done = 1'b1;
		@(negedge clk);
		check_val("o_rd_req", o_rd_req, 0); // Right after reset
		check_val("o_cmd_en", o_cmd_en, 0);
		check_val("o_reading", o_reading, 0);
		check_val("o_mem_rd_en", o_mem_rd_en, 0);
		check_val("o_buf_empty", o_buf_empty, 1);
		check_val("o_buf_pe", o_buf_pe, 1);
		@(posedge clk);
		#2;
		i_frame_en = 1'b1;
		for (int f = 0; f < NFRAMES; f++) begin
			wait_req("no read request after enable");
			answer_request(f);
			wait_frame_done();
			frame_on = 1'b0;
			check_val("commanded words", cmd_words, cur_size);
		end
		// Next request stays open while the video side empties the buffer
		wait_req("no read request after last frame");
		wait_drained();
		// One more frame with the video side stalled, then aborted by disable
		rd_hold = 1'b1;
		answer_request(NFRAMES);
		wait_buf_filled();
		check_val("o_buf_empty", o_buf_empty, 0);
		@(posedge clk);
		#2;
		i_frame_en = 1'b0;
		repeat (8) @(negedge clk);
		frame_on = 1'b0;
		exp_q.delete(); // Aborted frame
		for (int i = 0; i < 60; i++) begin
			check_val("o_rd_req", o_rd_req, 0);
			check_val("o_reading", o_reading, 0);
			check_val("o_cmd_en", o_cmd_en, 0);
			@(negedge clk);
		end
		check_val("o_buf_empty", o_buf_empty, 1); // Back buffer reset on disable
		check_val("o_buf_pe", o_buf_pe, 1);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: flist.f
+incdir+.
fb_cfg_pkg.sv
fb_mem_pkg.sv
fb_rd_cfg.sv
fb_async_fifo.sv
fb_rd_ctrl.sv
fb_rd_top.sv
tb_fb_rd_top.sv
